//--- common/cp0_consts.svh
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

`define CP0_W 32

// register numbers used by mfc0/mtc0
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// constant and reset values
`define CP0_PRID_VALUE   32'h0000_4220
`define CP0_CONFIG_RESET 32'h8000_0003
`define CP0_STATUS_RESET 32'h0040_0000
`define CP0_EPC_RESET    32'h8000_0000

// handler addresses, selected by status.bev
`define CP0_VEC_BOOT     32'hBFC0_0380
`define CP0_VEC_NORMAL   32'h8000_0180

`endif

//--- common/cp0_pkg.sv
`include "cp0_consts.svh"

package cp0_pkg;

	// status register, mips bit layout
	typedef struct packed {
		logic [2:0] rsvd_31_29;
		logic       cu0;
		logic [4:0] rsvd_27_23;
		logic       bev;
		logic [5:0] rsvd_21_16;
		logic [7:0] im;
		logic [2:0] rsvd_7_5;
		logic       um;
		logic       rsvd_3;
		logic       erl;
		logic       exl;
		logic       ie;
	} status_t;

	// cause register
	typedef struct packed {
		logic       bd;
		logic       ti;
		logic [5:0] rsvd_29_24;
		logic       iv;
		logic [6:0] rsvd_22_16;
		logic [7:0] ip;
		logic       rsvd_7;
		logic [4:0] exccode;
		logic [1:0] rsvd_1_0;
	} cause_t;

	typedef struct packed {
		logic [`CP0_W-1:0] bad_vaddr;
		logic [`CP0_W-1:0] count;
		logic [`CP0_W-1:0] compare;
		status_t           status;
		cause_t            cause;
		logic [`CP0_W-1:0] epc;
		logic [`CP0_W-1:0] config0;
	} cp0_regs_t;

	// one mtc0 word, seen either as status or as cause
	typedef union packed {
		logic [`CP0_W-1:0] raw;
		status_t           status;
		cause_t            cause;
	} cp0_wdata_u;

endpackage

//--- common/excp_pkg.sv
package excp_pkg;

	// listed from highest to lowest priority
	typedef struct packed {
		logic adel_fetch;
		logic reserved_instr;
		logic overflow;
		logic trap;
		logic syscall;
		logic adel_data;
		logic ades_data;
	} excp_flags_t;

	typedef enum logic [4:0] {
		INT  = 5'd0,
		ADEL = 5'd4,
		ADES = 5'd5,
		SYS  = 5'd8,
		BP   = 5'd9,
		RI   = 5'd10,
		OV   = 5'd12
	} exccode_t;

endpackage

//--- hdl/excp_prioritizer.sv
`timescale 1ns/1ns

`include "cp0_consts.svh"

module excp_prioritizer (
	input  excp_pkg::excp_flags_t flags,
	input  logic                  int_pending,
	input  logic [`CP0_W-1:0]     pc,
	input  logic [`CP0_W-1:0]     bad_addr,
	output excp_pkg::exccode_t    code,
	output logic                  bad_vaddr_we,
	output logic [`CP0_W-1:0]     bad_vaddr
);
	import excp_pkg::*;

	always_comb begin
		code = INT;
		bad_vaddr_we = 1'b0;
		bad_vaddr = pc;
		// interrupt beats every flag and captures no address
		if (int_pending) begin
			code = INT;
		end else if (flags.adel_fetch) begin
			code = ADEL;
			bad_vaddr_we = 1'b1;
			bad_vaddr = pc;
		end else if (flags.reserved_instr) begin
			code = RI;
		end else if (flags.overflow) begin
			code = OV;
		end else if (flags.trap) begin
			code = BP;
		end else if (flags.syscall) begin
			code = SYS;
		end else if (flags.adel_data) begin
			code = ADEL;
			bad_vaddr_we = 1'b1;
			bad_vaddr = bad_addr;
		end else if (flags.ades_data) begin
			code = ADES;
			bad_vaddr_we = 1'b1;
			bad_vaddr = bad_addr;
		end
	end

endmodule

//--- cp0/cp0_timer.sv
`timescale 1ns/1ns

`include "cp0_consts.svh"

module cp0_timer (
	input  logic              clk,
	input  logic              reset,
	input  logic              count_we,
	input  logic              compare_we,
	input  logic [`CP0_W-1:0] wr_data,
	output logic [`CP0_W-1:0] count,
	output logic [`CP0_W-1:0] compare,
	output logic              ti
);

	logic              phase;
	logic [`CP0_W-1:0] count_inc;

	assign count_inc = count + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= 1'b0;
			count <= '0;
			compare <= '0;
			ti <= 1'b0;
		end else begin
			phase <= ~phase;
			// a count write keeps the phase running
			if (count_we) begin
				count <= wr_data;
			end else if (phase) begin
				count <= count_inc;
			end
			if (compare_we) begin
				compare <= wr_data;
				ti <= 1'b0;
			end else if (phase && !count_we && count_inc == compare) begin
				ti <= 1'b1;
			end
		end
	end

	// ti only rises on a real count match, never on a compare write
	assert property (@(posedge clk) disable iff (reset)
		$rose(ti) |-> !$past(compare_we) && count == compare);

endmodule

//--- cp0/cp0_regfile.sv
`timescale 1ns/1ns

`include "cp0_consts.svh"

module cp0_regfile (
	input  logic                clk,
	input  logic                reset,
	input  logic [4:0]          rd_addr,
	input  logic [4:0]          wr_addr,
	input  logic                wr_en,
	input  logic [`CP0_W-1:0]   wr_data,
	input  logic                eret,
	input  logic [4:0]          ext_int,
	input  logic                take_exc,
	input  excp_pkg::exccode_t  exc_code,
	input  logic [`CP0_W-1:0]   exc_pc,
	input  logic                exc_is_slot,
	input  logic                bad_vaddr_we,
	input  logic [`CP0_W-1:0]   bad_vaddr,
	input  logic [`CP0_W-1:0]   count,
	input  logic [`CP0_W-1:0]   compare,
	input  logic                ti,
	output logic [`CP0_W-1:0]   rd_data,
	output logic                count_we,
	output logic                compare_we,
	output cp0_pkg::cp0_regs_t  regs
);
	import cp0_pkg::*;

	status_t           status_q;
	cause_t            cause_q;
	cause_t            cause_rd;
	logic [`CP0_W-1:0] epc_q;
	logic [`CP0_W-1:0] bad_vaddr_q;
	logic [`CP0_W-1:0] config_q;
	cp0_wdata_u        wd;
	logic              wr_ok;

	assign wd.raw = wr_data;

	// an exception at the same edge drops the write
	assign wr_ok = wr_en && !take_exc;
	assign count_we = wr_ok && wr_addr == `CP0_REG_COUNT;
	assign compare_we = wr_ok && wr_addr == `CP0_REG_COMPARE;

	always_ff @(posedge clk) begin
		if (reset) begin
			status_q <= `CP0_STATUS_RESET;
			cause_q <= '0;
			epc_q <= `CP0_EPC_RESET;
			bad_vaddr_q <= '0;
			config_q <= `CP0_CONFIG_RESET;
		end else if (take_exc) begin
			// nested exceptions keep the first epc and bd
			if (!status_q.exl) begin
				if (exc_is_slot) begin
					epc_q <= exc_pc - 32'd4;
					cause_q.bd <= 1'b1;
				end else begin
					epc_q <= exc_pc;
					cause_q.bd <= 1'b0;
				end
			end
			status_q.exl <= 1'b1;
			cause_q.exccode <= exc_code;
			if (bad_vaddr_we) begin
				bad_vaddr_q <= bad_vaddr;
			end
		end else if (wr_en) begin
			case (wr_addr)
				`CP0_REG_STATUS: begin
					status_q.cu0 <= wd.status.cu0;
					status_q.bev <= wd.status.bev;
					status_q.im <= wd.status.im;
					status_q.um <= wd.status.um;
					status_q.erl <= wd.status.erl;
					status_q.exl <= wd.status.exl;
					status_q.ie <= wd.status.ie;
				end
				`CP0_REG_CAUSE: begin
					cause_q.iv <= wd.cause.iv;
					// only the software interrupt bits
					cause_q.ip[1:0] <= wd.cause.ip[1:0];
				end
				`CP0_REG_EPC: epc_q <= wr_data;
				`CP0_REG_CONFIG: config_q[2:0] <= wr_data[2:0];
				default: ;
			endcase
		end else if (eret) begin
			status_q.exl <= 1'b0;
		end
	end

	// live hardware lines, timer shares ip[7]
	always_comb begin
		cause_rd = cause_q;
		cause_rd.ti = ti;
		cause_rd.ip[7:2] = {ext_int[4] | ti, ext_int};
	end

	always_comb begin
		case (rd_addr)
			`CP0_REG_BADVADDR: rd_data = bad_vaddr_q;
			`CP0_REG_COUNT: rd_data = count;
			`CP0_REG_COMPARE: rd_data = compare;
			`CP0_REG_STATUS: rd_data = status_q;
			`CP0_REG_CAUSE: rd_data = cause_rd;
			`CP0_REG_EPC: rd_data = epc_q;
			`CP0_REG_PRID: rd_data = `CP0_PRID_VALUE;
			`CP0_REG_CONFIG: rd_data = config_q;
			default: rd_data = '0;
		endcase
	end

	always_comb begin
		regs.bad_vaddr = bad_vaddr_q;
		regs.count = count;
		regs.compare = compare;
		regs.status = status_q;
		regs.cause = cause_q;
		regs.epc = epc_q;
		regs.config0 = config_q;
	end

	// mtc0 and eret come from different commit slots
	assert property (@(posedge clk) disable iff (reset) !(wr_en && eret));

endmodule

//--- hdl/trap_ctrl.sv
`timescale 1ns/1ns

`include "cp0_consts.svh"

module trap_ctrl (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  exc_req,
	input  excp_pkg::excp_flags_t exc_flags,
	input  cp0_pkg::cp0_regs_t    regs,
	input  logic [4:0]            ext_int,
	input  logic                  ti,
	output logic                  exc_ack,
	output logic                  take_exc,
	output logic                  int_pending,
	output logic [`CP0_W-1:0]     handler_pc
);

	logic       busy;
	logic [7:0] ip;

	// idle when low, waiting for req to drop when high
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (!busy) begin
			busy <= exc_req;
		end else if (!exc_req) begin
			busy <= 1'b0;
		end
	end

	assign exc_ack = busy;
	assign take_exc = !busy && exc_req;

	assign ip = {ext_int[4] | ti, ext_int, regs.cause.ip[1:0]};
	assign int_pending = regs.status.ie && !regs.status.exl && |(ip & regs.status.im);

	assign handler_pc = regs.status.bev ? `CP0_VEC_BOOT : `CP0_VEC_NORMAL;

	// req stays up until the pipeline has seen ack
	assert property (@(posedge clk) disable iff (reset) exc_req && !exc_ack |=> exc_req);

	// an accepted request must carry a reason
	assert property (@(posedge clk) disable iff (reset)
		take_exc |-> (exc_flags != '0) || int_pending);

endmodule

//--- hdl/cp0_top.sv
`timescale 1ns/1ns

`include "cp0_consts.svh"

module cp0_top (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [4:0]            rd_addr,
	output logic [`CP0_W-1:0]     rd_data,
	input  logic                  wr_en,
	input  logic [4:0]            wr_addr,
	input  logic [`CP0_W-1:0]     wr_data,
	input  logic                  eret,
	input  logic [4:0]            ext_int,
	input  logic                  exc_req,
	output logic                  exc_ack,
	input  excp_pkg::excp_flags_t exc_flags,
	input  logic [`CP0_W-1:0]     exc_pc,
	input  logic                  exc_is_slot,
	input  logic [`CP0_W-1:0]     exc_bad_addr,
	output logic                  int_pending,
	output logic [`CP0_W-1:0]     handler_pc,
	output logic [`CP0_W-1:0]     epc
);
	import cp0_pkg::*;
	import excp_pkg::*;

	cp0_regs_t         regs;
	exccode_t          code;
	logic              take_exc;
	logic              bad_vaddr_we;
	logic [`CP0_W-1:0] bad_vaddr;
	logic              count_we;
	logic              compare_we;
	logic [`CP0_W-1:0] count;
	logic [`CP0_W-1:0] compare;
	logic              ti;

	assign epc = regs.epc;

	cp0_timer u_timer (
		.clk(clk),
		.reset(reset),
		.count_we(count_we),
		.compare_we(compare_we),
		.wr_data(wr_data),
		.count(count),
		.compare(compare),
		.ti(ti)
	);

	excp_prioritizer u_prio (
		.flags(exc_flags),
		.int_pending(int_pending),
		.pc(exc_pc),
		.bad_addr(exc_bad_addr),
		.code(code),
		.bad_vaddr_we(bad_vaddr_we),
		.bad_vaddr(bad_vaddr)
	);

	cp0_regfile u_regfile (
		.clk(clk),
		.reset(reset),
		.rd_addr(rd_addr),
		.wr_addr(wr_addr),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.eret(eret),
		.ext_int(ext_int),
		.take_exc(take_exc),
		.exc_code(code),
		.exc_pc(exc_pc),
		.exc_is_slot(exc_is_slot),
		.bad_vaddr_we(bad_vaddr_we),
		.bad_vaddr(bad_vaddr),
		.count(count),
		.compare(compare),
		.ti(ti),
		.rd_data(rd_data),
		.count_we(count_we),
		.compare_we(compare_we),
		.regs(regs)
	);

	trap_ctrl u_trap (
		.clk(clk),
		.reset(reset),
		.exc_req(exc_req),
		.exc_flags(exc_flags),
		.regs(regs),
		.ext_int(ext_int),
		.ti(ti),
		.exc_ack(exc_ack),
		.take_exc(take_exc),
		.int_pending(int_pending),
		.handler_pc(handler_pc)
	);

endmodule

//--- tests/cp0_model.svh
`ifndef CP0_MODEL_SVH
`define CP0_MODEL_SVH

// architectural state as the pipeline should see it
logic [31:0] m_status;
logic [31:0] m_epc;
logic [31:0] m_badv;
logic [31:0] m_config;
logic [31:0] m_count;
logic [31:0] m_compare;
logic        m_bd;
logic        m_iv;
logic        m_ti;
logic        m_phase;
logic        m_busy;
logic [1:0]  m_swip;
logic [4:0]  m_exccode;

task model_reset();
	m_status = `CP0_STATUS_RESET;
	m_epc = `CP0_EPC_RESET;
	m_badv = 32'h0;
	m_config = `CP0_CONFIG_RESET;
	m_count = 32'h0;
	m_compare = 32'h0;
	m_bd = 1'b0;
	m_iv = 1'b0;
	m_ti = 1'b0;
	m_phase = 1'b0;
	m_busy = 1'b0;
	m_swip = 2'b00;
	m_exccode = 5'd0;
endtask

// timer shares line 7 with the top external line
function logic [7:0] model_ip(input logic [4:0] ext);
	model_ip = {ext[4] | m_ti, ext, m_swip};
endfunction

function logic model_int_pending(input logic [4:0] ext);
	model_int_pending = m_status[0] && !m_status[1] && (|(model_ip(ext) & m_status[15:8]));
endfunction

function logic [4:0] model_code(input logic [6:0] f, input logic intp);
	if (intp) model_code = 5'd0;
	else if (f[6]) model_code = 5'd4;
	else if (f[5]) model_code = 5'd10;
	else if (f[4]) model_code = 5'd12;
	else if (f[3]) model_code = 5'd9;
	else if (f[2]) model_code = 5'd8;
	else if (f[1]) model_code = 5'd4;
	else model_code = 5'd5;
endfunction

function logic [31:0] model_read(input logic [4:0] addr, input logic [4:0] ext);
	case (addr)
		`CP0_REG_BADVADDR: model_read = m_badv;
		`CP0_REG_COUNT: model_read = m_count;
		`CP0_REG_COMPARE: model_read = m_compare;
		`CP0_REG_STATUS: model_read = m_status;
		`CP0_REG_CAUSE: model_read = {m_bd, m_ti, 6'b0, m_iv, 7'b0, model_ip(ext), 1'b0,
			m_exccode, 2'b0};
		`CP0_REG_EPC: model_read = m_epc;
		`CP0_REG_PRID: model_read = 32'h0000_4220;
		`CP0_REG_CONFIG: model_read = m_config;
		default: model_read = 32'h0;
	endcase
endfunction

// one clock edge, all arguments are the values sampled at that edge
task model_update(input logic we, input logic [4:0] waddr, input logic [31:0] wdata,
		input logic er, input logic req, input logic [6:0] f, input logic [31:0] pc,
		input logic slot, input logic [31:0] baddr, input logic [4:0] ext);
	logic        intp;
	logic        take;
	logic        cnt_we;
	logic        cmp_we;
	logic [31:0] inc;
	intp = model_int_pending(ext);
	take = !m_busy && req;
	cnt_we = we && !take && waddr == `CP0_REG_COUNT;
	cmp_we = we && !take && waddr == `CP0_REG_COMPARE;
	inc = m_count + 32'd1;
	if (cmp_we) m_ti = 1'b0;
	else if (m_phase && !cnt_we && inc == m_compare) m_ti = 1'b1;
	if (cnt_we) m_count = wdata;
	else if (m_phase) m_count = inc;
	if (cmp_we) m_compare = wdata;
	m_phase = !m_phase;
	if (!m_busy) m_busy = req;
	else if (!req) m_busy = 1'b0;
	if (take) begin
		if (!m_status[1]) begin
			m_epc = slot ? pc - 32'd4 : pc;
			m_bd = slot;
		end
		m_status[1] = 1'b1;
		m_exccode = model_code(f, intp);
		if (!intp && f[6]) m_badv = pc;
		else if (!intp && f[6:2] == 5'b0 && (f[1] || f[0])) m_badv = baddr;
	end else if (we) begin
		case (waddr)
			`CP0_REG_STATUS: m_status = (m_status & ~32'h1040_FF17) | (wdata & 32'h1040_FF17);
			`CP0_REG_CAUSE: begin
				m_iv = wdata[23];
				m_swip = wdata[9:8];
			end
			`CP0_REG_EPC: m_epc = wdata;
			`CP0_REG_CONFIG: m_config[2:0] = wdata[2:0];
			default: ;
		endcase
	end else if (er) begin
		m_status[1] = 1'b0;
	end
endtask

`endif

//--- tests/cp0_tb.sv
`timescale 1ns/1ns

`include "cp0_consts.svh"

module cp0_tb;

	localparam int NUM_OPS = 400;
	localparam int WATCHDOG_NS = (NUM_OPS * 8 + 200) * 100;

	logic        clk;
	logic        reset;
	logic [4:0]  rd_addr;
	logic [31:0] rd_data;
	logic        wr_en;
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;
	logic        eret;
	logic [4:0]  ext_int;
	logic        exc_req;
	logic        exc_ack;
	logic [6:0]  exc_flags;
	logic [31:0] exc_pc;
	logic        exc_is_slot;
	logic [31:0] exc_bad_addr;
	logic        int_pending;
	logic [31:0] handler_pc;
	logic [31:0] epc;
	integer      seed;
	logic [4:0]  known_regs [8];

	`include "cp0_model.svh"

	cp0_top dut (
		.clk(clk),
		.reset(reset),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.eret(eret),
		.ext_int(ext_int),
		.exc_req(exc_req),
		.exc_ack(exc_ack),
		.exc_flags(exc_flags),
		.exc_pc(exc_pc),
		.exc_is_slot(exc_is_slot),
		.exc_bad_addr(exc_bad_addr),
		.int_pending(int_pending),
		.handler_pc(handler_pc),
		.epc(epc)
	);

	always #50 clk = ~clk;

	function int unsigned rand_below(input int unsigned n);
		rand_below = $unsigned($random(seed)) % n;
	endfunction

	function logic [31:0] rand_word();
		rand_word = $unsigned($random(seed));
	endfunction

	task expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1);
		end
	endtask

	// update the model with the inputs the DUT samples at this edge
	task next_edge();
		@(posedge clk);
		if (reset) begin
			model_reset();
		end else begin
			model_update(wr_en, wr_addr, wr_data, eret, exc_req, exc_flags, exc_pc,
				exc_is_slot, exc_bad_addr, ext_int);
		end
	endtask

	task settle_and_check();
		@(negedge clk);
		if (!reset) begin
			expect_equal("rd_data", rd_data, model_read(rd_addr, ext_int));
			expect_equal("int_pending", {31'b0, int_pending},
				{31'b0, model_int_pending(ext_int)});
			expect_equal("exc_ack", {31'b0, exc_ack}, {31'b0, m_busy});
			expect_equal("epc", epc, m_epc);
			expect_equal("handler_pc", handler_pc,
				m_status[22] ? `CP0_VEC_BOOT : `CP0_VEC_NORMAL);
		end
	endtask

	task idle_cycle(input logic [4:0] addr);
		next_edge();
		wr_en <= 1'b0;
		eret <= 1'b0;
		rd_addr <= addr;
		settle_and_check();
	endtask

	task write_reg(input logic [4:0] addr, input logic [31:0] data);
		next_edge();
		wr_en <= 1'b1;
		wr_addr <= addr;
		wr_data <= data;
		settle_and_check();
		idle_cycle(addr);
	endtask

	task run_exception();
		logic [6:0] flags;
		flags = rand_below(2) == 0 ? 7'(rand_below(128)) : 7'(1 << rand_below(7));
		if (flags == 7'b0 && !model_int_pending(ext_int)) flags = 7'(1 << rand_below(7));
		next_edge();
		exc_req <= 1'b1;
		exc_flags <= flags;
		exc_pc <= rand_word() & 32'hFFFF_FFFC;
		exc_is_slot <= 1'(rand_below(2));
		exc_bad_addr <= rand_word();
		// a write in the same cycle must be dropped
		wr_en <= 1'(rand_below(4) == 0);
		wr_addr <= known_regs[rand_below(8)];
		wr_data <= rand_word();
		settle_and_check();
		// ack is due exactly one edge after req
		idle_cycle(`CP0_REG_STATUS);
		next_edge();
		exc_req <= 1'b0;
		rd_addr <= `CP0_REG_CAUSE;
		settle_and_check();
		while (exc_ack) idle_cycle(`CP0_REG_BADVADDR);
		idle_cycle(`CP0_REG_STATUS);
	endtask

	task run_timer_match();
		write_reg(`CP0_REG_STATUS, 32'h0000_8001 | (32'(rand_below(2)) << 22));
		write_reg(`CP0_REG_COMPARE, m_count + 32'd1 + 32'(rand_below(4)));
		repeat (6) idle_cycle(`CP0_REG_CAUSE);
		write_reg(`CP0_REG_COMPARE, rand_word());
	endtask

	initial begin
		#WATCHDOG_NS;
		$display("ERROR: watchdog expired before the tests finished");
		$display("SIMULATION FAILED");
		$fatal(1);
	end

	initial begin
		seed = 76686;
		known_regs = '{5'd8, 5'd9, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15, 5'd16};
		clk = 1'b0;
		reset = 1'b1;
		rd_addr = 5'd0;
		wr_en = 1'b0;
		wr_addr = 5'd0;
		wr_data = 32'h0;
		eret = 1'b0;
		ext_int = 5'd0;
		exc_req = 1'b0;
		exc_flags = 7'd0;
		exc_pc = 32'h0;
		exc_is_slot = 1'b0;
		exc_bad_addr = 32'h0;
		model_reset();
		repeat (4) next_edge();
		reset <= 1'b0;
		for (int i = 0; i < 32; i++) idle_cycle(5'(i));
		for (int op = 0; op < NUM_OPS; op++) begin
			case (rand_below(10))
				0, 1: write_reg(known_regs[rand_below(8)], rand_word());
				2: write_reg(5'(rand_below(32)), rand_word());
				3: write_reg(`CP0_REG_STATUS, rand_word());
				4: begin
					next_edge();
					ext_int <= 5'(rand_below(32));
					rd_addr <= `CP0_REG_CAUSE;
					settle_and_check();
				end
				5: begin
					next_edge();
					eret <= 1'b1;
					rd_addr <= `CP0_REG_STATUS;
					settle_and_check();
					idle_cycle(`CP0_REG_EPC);
				end
				6, 7: run_exception();
				8: run_timer_match();
				default: idle_cycle(`CP0_REG_COUNT);
			endcase
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- build.f
+incdir+common
+incdir+tests
common/cp0_pkg.sv
common/excp_pkg.sv
hdl/excp_prioritizer.sv
cp0/cp0_timer.sv
cp0/cp0_regfile.sv
hdl/trap_ctrl.sv
hdl/cp0_top.sv
tests/cp0_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the CP0 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module cp0_tb -o cp0_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/cp0_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi
exit 0
